/* Makefile */
VERILATOR = verilator
TOP       = mem_wb_tb
FILELIST  = files.f
FLAGS     = --timing --assert
OBJ_DIR   = obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* files.f */
+incdir+verilog
verilog/riscv_wb_pkg.sv
verilog/dmem_if.sv
verilog/mem_access.sv
verilog/data_mem.sv
verilog/riscv_wb.sv
verilog/mem_wb_top.sv
tests/tb_clkgen.sv
tests/mem_wb_asserts.sv
tests/mem_wb_tb.sv

/* tests/mem_wb_asserts.sv */
// Handshake, memory request and register write rules on the memory access and write-back top
`timescale 1ns/10ps
`include "riscv_wb_cfg.svh"

module mem_wb_asserts (
  input logic                  clk,
  input logic                  rstn,
  input logic                  in_ready,
  input logic                  req,
  input logic                  ack,
  input logic                  we,
  input logic [`RV_XLEN/8-1:0] be,
  input logic [`RV_XLEN-1:0]   adr,
  input logic [`RV_XLEN-1:0]   d,
  input logic                  wb_valid,
  input logic                  wb_we
);

  // Waiting access pushes back on the input
  a_stall_blocks_input: assert property (@(posedge clk) disable iff (!rstn)
    (req && !ack) |-> !in_ready)
    else $error("in_ready high while the memory access is still waiting");

  // No answer without a request
  a_ack_needs_req: assert property (@(posedge clk) disable iff (!rstn)
    ack |-> req)
    else $error("ack raised without req");

  // Request and payload held until ack
  a_req_stable: assert property (@(posedge clk) disable iff (!rstn)
    (req && !ack) |=> (req && $stable(we) && $stable(be) && $stable(adr) && $stable(d)))
    else $error("memory request changed before ack");

  a_we_with_valid: assert property (@(posedge clk) disable iff (!rstn)
    wb_we |-> wb_valid)
    else $error("wb_we high without wb_valid");

endmodule

bind mem_wb_top mem_wb_asserts u_asserts (
  .clk      (clk),
  .rstn     (rstn),
  .in_ready (in_ready),
  .req      (dmem.req),
  .ack      (dmem.ack),
  .we       (dmem.we),
  .be       (dmem.be),
  .adr      (dmem.adr),
  .d        (dmem.d),
  .wb_valid (wb_valid),
  .wb_we    (wb_we)
);

/* tests/mem_wb_tb.sv */
// Testbench for the memory access and write-back slice with a shadow memory reference
`timescale 1ns/10ps
`include "riscv_wb_cfg.svh"

module mem_wb_tb;

  // Instruction counts per phase
  localparam int N_INIT      = 16;
  localparam int N_ALU       = 24;
  localparam int N_SWEEP     = 72;
  localparam int N_FAULT     = 12;
  localparam int N_RAND      = 120;
  localparam int N_TOTAL     = N_INIT + N_ALU + N_SWEEP + N_FAULT + N_RAND;
  localparam int CYCLE_LIMIT = 6 * N_TOTAL + 50;

  // Expected write-back record
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] instr;
    logic [15:0] exc;
    logic [31:0] badaddr;
    logic        we;
    logic [4:0]  dst;
    logic [31:0] r;
  } exp_t;

  logic clk, rstn, in_valid, in_ready, wb_valid, wb_we;
  logic [31:0] in_pc, in_instr, in_r, in_adr, wb_pc, wb_instr, wb_badaddr, wb_r;
  logic [15:0] wb_exception;
  logic [4:0]  wb_dst;

  logic [7:0]  shadow [4*`RV_DMEM_WORDS];
  exp_t        exp_q [$];
  exp_t        cur;
  logic [31:0] rng = 32'h6779_8c62;
  logic [31:0] pc_next = 32'h1000;
  int          sent_cnt = 0;
  int          rcv_cnt = 0;
  int          cycles = 0;

  riscv_wb_pkg::opcode_e alu_ops [12] = '{
    riscv_wb_pkg::OPC_OP, riscv_wb_pkg::OPC_OP_IMM, riscv_wb_pkg::OPC_LUI,
    riscv_wb_pkg::OPC_AUIPC, riscv_wb_pkg::OPC_JAL, riscv_wb_pkg::OPC_JALR,
    riscv_wb_pkg::OPC_SYSTEM, riscv_wb_pkg::OPC_BRANCH, riscv_wb_pkg::OPC_MISC_MEM,
    riscv_wb_pkg::OPC_STORE_FP, riscv_wb_pkg::OPC_OP, riscv_wb_pkg::OPC_OP_IMM};
  riscv_wb_pkg::mem_size_e load_sizes [5] = '{
    riscv_wb_pkg::SZ_B, riscv_wb_pkg::SZ_H, riscv_wb_pkg::SZ_W,
    riscv_wb_pkg::SZ_BU, riscv_wb_pkg::SZ_HU};

  tb_clkgen u_clkgen (.clk(clk), .rstn(rstn));

  mem_wb_top uut (
    .clk(clk), .rstn(rstn), .in_valid(in_valid), .in_ready(in_ready),
    .in_pc(in_pc), .in_instr(in_instr), .in_r(in_r), .in_adr(in_adr),
    .wb_pc(wb_pc), .wb_instr(wb_instr), .wb_valid(wb_valid),
    .wb_exception(wb_exception), .wb_badaddr(wb_badaddr), .wb_dst(wb_dst),
    .wb_r(wb_r), .wb_we(wb_we)
  );

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "Run aborted");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual)
      abort_run($sformatf("Mismatch at %0t: %s expected %h actual %h",
                          $time, name, expected, actual));
  endtask

  // Expected result from the access rules with the shadow memory updated in program order
  function automatic exp_t predict(input logic [31:0] pc, input logic [31:0] instr,
                                   input logic [31:0] r, input logic [31:0] adr);
    exp_t        e;
    logic [4:0]  opc;
    logic [2:0]  f3;
    logic        is_ld;
    logic        is_st;
    logic [31:0] v;
    int          n;
    opc   = instr[6:2];
    f3    = instr[14:12];
    is_ld = (opc == riscv_wb_pkg::OPC_LOAD);
    is_st = (opc == riscv_wb_pkg::OPC_STORE);
    case (f3)
      riscv_wb_pkg::SZ_B, riscv_wb_pkg::SZ_BU: n = 1;
      riscv_wb_pkg::SZ_H, riscv_wb_pkg::SZ_HU: n = 2;
      default:                                 n = 4;
    endcase
    e.pc    = pc;
    e.instr = instr;
    e.dst   = instr[11:7];
    e.r     = r;
    e.exc   = '0;
    if (is_ld || is_st)
    begin
      // Misaligned and out-of-range flags into load or store causes
      e.exc[is_ld ? 4 : 6] = (n == 2 && adr[0]) || (n == 4 && adr[1:0] != 2'b00);
      e.exc[is_ld ? 5 : 7] = (adr >= 32'(4 * `RV_DMEM_WORDS));
    end
    e.badaddr = (|e.exc) ? adr : pc;
    e.we = ~|e.exc && (e.dst != 5'd0) && !is_st && opc != riscv_wb_pkg::OPC_STORE_FP
           && opc != riscv_wb_pkg::OPC_BRANCH && opc != riscv_wb_pkg::OPC_MISC_MEM;
    if (is_ld && ~|e.exc)
    begin
      v = '0;
      for (int i = 0; i < n; i++)
        v[8*i +: 8] = shadow[int'(adr[9:0]) + i];
      if (f3 == riscv_wb_pkg::SZ_B)
        v = {{24{v[7]}}, v[7:0]};
      else if (f3 == riscv_wb_pkg::SZ_H)
        v = {{16{v[15]}}, v[15:0]};
      e.r = v;
    end
    // Flagged stores leave memory alone
    if (is_st && ~|e.exc)
      for (int i = 0; i < n; i++)
        shadow[int'(adr[9:0]) + i] = r[8*i +: 8];
    return e;
  endfunction

  // Drive one instruction 1 ns after the edge and hold it until in_ready
  task automatic send_instr(input riscv_wb_pkg::opcode_e opc, input logic [2:0] f3,
                            input logic [4:0] rd, input logic [31:0] r,
                            input logic [31:0] adr, input int max_gap);
    int          gap;
    logic [31:0] instr;
    gap   = (max_gap > 0) ? int'(next_rand() % 32'(max_gap + 1)) : 0;
    instr = {17'h0, f3, rd, opc, 2'b11};
    repeat (gap)
    begin
      @(posedge clk);
      #1;
    end
    in_valid = 1'b1;
    in_pc    = pc_next;
    in_instr = instr;
    in_r     = r;
    in_adr   = adr;
    while (!in_ready)
    begin
      @(posedge clk);
      #1;
    end
    exp_q.push_back(predict(pc_next, instr, r, adr));
    pc_next  = pc_next + 32'd4;
    sent_cnt = sent_cnt + 1;
    @(posedge clk);
    #1 in_valid = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // Compare and timeout
  ////////////////////////////////////////////////////////////

  // Registered outputs sampled on the falling edge
  always @(negedge clk)
    if (rstn && wb_valid)
    begin
      if (exp_q.size() == 0)
        abort_run("Write-back produced an instruction that was never sent");
      else
      begin
        cur = exp_q.pop_front();
        check_value("wb_pc", cur.pc, wb_pc);
        check_value("wb_instr", cur.instr, wb_instr);
        check_value("wb_exception", 32'(cur.exc), 32'(wb_exception));
        check_value("wb_badaddr", cur.badaddr, wb_badaddr);
        check_value("wb_we", 32'(cur.we), 32'(wb_we));
        if (cur.we)
        begin
          check_value("wb_dst", 32'(cur.dst), 32'(wb_dst));
          check_value("wb_r", cur.r, wb_r);
        end
        rcv_cnt = rcv_cnt + 1;
      end
    end

  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles > CYCLE_LIMIT)
      abort_run("Timeout: write-back did not return every instruction in time");
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial
  begin
    logic [31:0] rnd;
    logic [31:0] adr;
    in_valid = 1'b0;
    in_pc    = '0;
    in_instr = '0;
    in_r     = '0;
    in_adr   = '0;

    // Reset values while rstn is low
    @(posedge clk);
    #1;
    check_value("wb_valid", 32'd0, 32'(wb_valid));
    check_value("wb_we", 32'd0, 32'(wb_we));
    check_value("in_ready", 32'd1, 32'(in_ready));
    check_value("wb_pc", 32'(`RV_PC_INIT), wb_pc);
    wait (rstn);

    // Fill words 0 to 15 so every later load reads known data
    for (int w = 0; w < N_INIT; w++)
      send_instr(riscv_wb_pkg::OPC_STORE, riscv_wb_pkg::SZ_W, 5'd0, next_rand(), 32'(4 * w), 0);

    // Non-memory opcodes with one destination x0
    for (int i = 0; i < N_ALU; i++)
    begin
      rnd = next_rand();
      send_instr(alu_ops[i % 12], rnd[14:12], (i == 12) ? 5'd0 : rnd[11:7], next_rand(), rnd, 0);
    end

    // Every store size then every load size at each offset of word 4
    for (int off = 0; off < 4; off++)
      for (int s = 0; s < 3; s++)
      begin
        send_instr(riscv_wb_pkg::OPC_STORE, 3'(s), 5'd0, next_rand(), 32'(16 + off), 0);
        for (int l = 0; l < 5; l++)
          send_instr(riscv_wb_pkg::OPC_LOAD, load_sizes[l], 5'(1 + l), 32'h0, 32'(16 + off), 0);
      end

    // Out of range stores and loads
    for (int i = 0; i < 6; i++)
    begin
      send_instr(riscv_wb_pkg::OPC_STORE, 3'(i % 3), 5'd0, next_rand(), 32'h400 << i, 0);
      send_instr(riscv_wb_pkg::OPC_LOAD, load_sizes[i % 5], 5'd9, 32'h0, 32'h400 << i, 0);
    end

    // Random mix with input gaps
    for (int i = 0; i < N_RAND; i++)
    begin
      rnd = next_rand();
      if (rnd[7:4] < 4'd3)
        adr = 32'h400 + {20'h0, rnd[19:8]};
      else
        adr = {26'h0, rnd[13:8]};
      case (rnd[1:0])
        2'd0: send_instr(riscv_wb_pkg::OPC_LOAD, load_sizes[int'(rnd[26:24]) % 5],
                         rnd[22:18], 32'h0, adr, 2);
        2'd1: send_instr(riscv_wb_pkg::OPC_STORE, 3'(int'(rnd[25:24]) % 3),
                         rnd[22:18], next_rand(), adr, 2);
        default: send_instr(alu_ops[int'(rnd[27:24]) % 12], rnd[30:28],
                            rnd[22:18], next_rand(), adr, 2);
      endcase
    end

    // Drain and idle a few cycles to catch extra write-backs
    wait (rcv_cnt == sent_cnt);
    repeat (4) @(posedge clk);
    if (exp_q.size() != 0 || sent_cnt != N_TOTAL)
      abort_run("Instruction count does not match the number sent");
    else
    begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

/* tests/tb_clkgen.sv */
// Clock and reset source for the memory access and write-back testbench
`timescale 1ns/10ps

module tb_clkgen (
  output logic clk,
  output logic rstn
);

  // 10 ns period
  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Reset low for four rising edges
  initial
  begin
    rstn = 1'b0;
    repeat (4) @(posedge clk);
    #1 rstn = 1'b1;
  end

endmodule

/* verilog/data_mem.sv */
// Word-wide data memory with byte enables, random acknowledge delay and fault checks
`timescale 1ns/10ps
`include "riscv_wb_cfg.svh"

module data_mem #(
  parameter int WORDS = `RV_DMEM_WORDS
)
(
  input  logic clk,
  input  logic rstn,
  dmem_if.mem  bus
);

  localparam int AW     = $clog2(WORDS);
  localparam int WAIT_W = $clog2(`RV_DMEM_MAX_WAIT + 1);

  logic [`RV_XLEN-1:0] mem [WORDS];
  logic [7:0]          lfsr;
  logic [WAIT_W-1:0]   wait_new;
  logic [WAIT_W-1:0]   wait_cnt;
  logic                pend;
  logic [AW-1:0]       idx;
  logic                lanes_ok;
  logic                do_write;

  ////////////////////////////////////////////////////////////
  // Acknowledge timing
  ////////////////////////////////////////////////////////////

  // Free-running LFSR with polynomial x^8+x^6+x^5+x^4+1
  always_ff @(posedge clk or negedge rstn)
    if (!rstn)
      lfsr <= 8'ha5;
    else
      lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};

  // Wait for a new request clamped to the limit
  always_comb
    if (lfsr[WAIT_W-1:0] > WAIT_W'(`RV_DMEM_MAX_WAIT))
      wait_new = WAIT_W'(`RV_DMEM_MAX_WAIT);
    else
      wait_new = lfsr[WAIT_W-1:0];

  // Zero wait answers in the request cycle
  assign bus.ack = bus.req & (pend ? (wait_cnt == '0) : (wait_new == '0));

  always_ff @(posedge clk or negedge rstn)
    if (!rstn)
    begin
      pend     <= 1'b0;
      wait_cnt <= '0;
    end
    else if (bus.ack)
      pend <= 1'b0;
    else if (bus.req && !pend)
    begin
      pend     <= 1'b1;
      wait_cnt <= wait_new - WAIT_W'(1);
    end
    else if (pend)
      wait_cnt <= wait_cnt - WAIT_W'(1);

  ////////////////////////////////////////////////////////////
  // Checks and array
  ////////////////////////////////////////////////////////////

  assign idx = bus.adr[AW+1:2];

  // Lane mask has to match the offset
  always_comb
    case (bus.adr[1:0])
      2'd0:    lanes_ok = (bus.be == 4'b0001) | (bus.be == 4'b0011) | (bus.be == 4'b1111);
      2'd1:    lanes_ok = (bus.be == 4'b0010);
      2'd2:    lanes_ok = (bus.be == 4'b0100) | (bus.be == 4'b1100);
      default: lanes_ok = (bus.be == 4'b1000);
    endcase

  assign bus.misaligned = ~lanes_ok;
  assign bus.fault      = bus.adr >= `RV_XLEN'(4 * WORDS);

  // Whole word back so write-back picks the lanes
  assign bus.q = bus.fault ? '0 : mem[idx];

  // Flagged stores leave the array alone
  assign do_write = bus.ack & bus.we & ~bus.misaligned & ~bus.fault;

  always_ff @(posedge clk)
    if (do_write)
      for (int i = 0; i < `RV_XLEN/8; i++)
        if (bus.be[i])
          mem[idx][8*i +: 8] <= bus.d[8*i +: 8];

endmodule

/* verilog/dmem_if.sv */
// Data memory request and response bundle shared by the memory stage and write-back
`timescale 1ns/10ps
`include "riscv_wb_cfg.svh"

interface dmem_if;

  // Request side, from the memory stage
  logic                  req;
  logic                  we;
  logic [`RV_XLEN/8-1:0] be;
  logic [`RV_XLEN-1:0]   adr;
  logic [`RV_XLEN-1:0]   d;

  // Response side, from the data memory
  // Flags only meaningful together with ack
  logic                  ack;
  logic [`RV_XLEN-1:0]   q;
  logic                  misaligned;
  logic                  fault;

  // Memory stage issues the access
  modport lsu (output req, we, be, adr, d);

  // Memory answers it
  modport mem (
    input  req, we, be, adr, d,
    output ack, q, misaligned, fault
  );

  // Write-back only watches the exchange
  modport wb (input req, adr, ack, q, misaligned, fault);

endinterface

/* verilog/mem_access.sv */
// Memory stage register that accepts executed instructions and issues loads and stores
`timescale 1ns/10ps
`include "riscv_wb_cfg.svh"

module mem_access (
  input  logic                     clk,
  input  logic                     rstn,

  // Upstream handshake
  input  logic                     in_valid,
  output logic                     in_ready,
  input  logic [`RV_XLEN-1:0]      in_pc,
  input  logic [`RV_ILEN-1:0]      in_instr,
  input  logic [`RV_XLEN-1:0]      in_r,
  input  logic [`RV_XLEN-1:0]      in_adr,

  // Back-pressure from write-back
  input  logic                     wb_stall,
  output riscv_wb_pkg::mem_stage_t stage,

  dmem_if.lsu                      dmem
);

  ////////////////////////////////////////////////////////////
  // Stage register
  ////////////////////////////////////////////////////////////

  logic                  take;
  logic                  bubble_q;
  logic [`RV_XLEN-1:0]   pc_q;
  logic [`RV_ILEN-1:0]   instr_q;
  logic [`RV_XLEN-1:0]   r_q;
  logic [`RV_XLEN-1:0]   adr_q;

  riscv_wb_pkg::opcode_e   opcode;
  riscv_wb_pkg::mem_size_e size;
  logic                    is_load;
  logic                    is_store;
  logic [`RV_XLEN/8-1:0]   be;

  // Accept only while write-back moves
  assign in_ready = ~wb_stall;
  assign take     = in_valid & in_ready;

  // Edge without a transfer loads a bubble
  always_ff @(posedge clk or negedge rstn)
    if (!rstn)
      bubble_q <= 1'b1;
    else if (!wb_stall)
      bubble_q <= ~take;

  // Payload only changes on a transfer
  always_ff @(posedge clk)
    if (take)
    begin
      pc_q    <= in_pc;
      instr_q <= in_instr;
      r_q     <= in_r;
      adr_q   <= in_adr;
    end

  always_comb
  begin
    stage.pc     = pc_q;
    stage.instr  = instr_q;
    stage.r      = r_q;
    stage.adr    = adr_q;
    stage.bubble = bubble_q;
  end

  ////////////////////////////////////////////////////////////
  // Access decode
  ////////////////////////////////////////////////////////////

  assign opcode   = riscv_wb_pkg::opcode_e'(instr_q[6:2]);
  assign size     = riscv_wb_pkg::mem_size_e'(instr_q[14:12]);
  assign is_load  = ~bubble_q & (opcode == riscv_wb_pkg::OPC_LOAD);
  assign is_store = ~bubble_q & (opcode == riscv_wb_pkg::OPC_STORE);

  // Byte lanes for the access
  // An empty mask means the access does not fit its lanes
  always_comb
    case (size)
      riscv_wb_pkg::SZ_B,
      riscv_wb_pkg::SZ_BU: be = 4'b0001 << adr_q[1:0];
      riscv_wb_pkg::SZ_H,
      riscv_wb_pkg::SZ_HU: be = adr_q[0] ? 4'b0000 : 4'b0011 << adr_q[1:0];
      riscv_wb_pkg::SZ_W:  be = (|adr_q[1:0]) ? 4'b0000 : 4'b1111;
      default:             be = 4'b0000;
    endcase

  // Request held while the stage holds the access
  assign dmem.req = is_load | is_store;
  assign dmem.we  = is_store;
  assign dmem.be  = be;
  assign dmem.adr = adr_q;

  // Store data moved onto its byte lanes
  assign dmem.d   = r_q << {adr_q[1:0], 3'b000};

endmodule

/* verilog/mem_wb_top.sv */
// Memory access and write-back slice top level joining stage, data memory and write-back
`timescale 1ns/10ps
`include "riscv_wb_cfg.svh"

module mem_wb_top (
  input  logic                    clk,
  input  logic                    rstn,

  // Executed instruction input
  input  logic                    in_valid,
  output logic                    in_ready,
  input  logic [`RV_XLEN-1:0]     in_pc,
  input  logic [`RV_ILEN-1:0]     in_instr,
  input  logic [`RV_XLEN-1:0]     in_r,
  input  logic [`RV_XLEN-1:0]     in_adr,

  // Write-back results
  output logic [`RV_XLEN-1:0]     wb_pc,
  output logic [`RV_ILEN-1:0]     wb_instr,
  output logic                    wb_valid,
  output logic [`RV_EXC_SIZE-1:0] wb_exception,
  output logic [`RV_XLEN-1:0]     wb_badaddr,
  output logic [4:0]              wb_dst,
  output logic [`RV_XLEN-1:0]     wb_r,
  output logic                    wb_we
);

  riscv_wb_pkg::mem_stage_t stage;
  logic                     wb_stall;

  // Shared memory bus
  dmem_if dmem ();

  mem_access u_mem_access (
    .clk      (clk),
    .rstn     (rstn),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .in_pc    (in_pc),
    .in_instr (in_instr),
    .in_r     (in_r),
    .in_adr   (in_adr),
    .wb_stall (wb_stall),
    .stage    (stage),
    .dmem     (dmem.lsu)
  );

  data_mem #(
    .WORDS (`RV_DMEM_WORDS)
  ) u_data_mem (
    .clk  (clk),
    .rstn (rstn),
    .bus  (dmem.mem)
  );

  riscv_wb u_riscv_wb (
    .clk          (clk),
    .rstn         (rstn),
    .stage        (stage),
    .dmem         (dmem.wb),
    .wb_stall     (wb_stall),
    .wb_pc        (wb_pc),
    .wb_instr     (wb_instr),
    .wb_valid     (wb_valid),
    .wb_exception (wb_exception),
    .wb_badaddr   (wb_badaddr),
    .wb_dst       (wb_dst),
    .wb_r         (wb_r),
    .wb_we        (wb_we)
  );

endmodule

/* verilog/riscv_wb.sv */
// Write-back stage with load alignment, exception merge, stall and register write
`timescale 1ns/10ps
`include "riscv_wb_cfg.svh"

module riscv_wb (
  input  logic                     clk,
  input  logic                     rstn,
  input  riscv_wb_pkg::mem_stage_t stage,
  dmem_if.wb                       dmem,

  // Memory wait
  output logic                     wb_stall,

  output logic [`RV_XLEN-1:0]      wb_pc,
  output logic [`RV_ILEN-1:0]      wb_instr,
  output logic                     wb_valid,
  output logic [`RV_EXC_SIZE-1:0]  wb_exception,
  output logic [`RV_XLEN-1:0]      wb_badaddr,

  // Register file write port
  output logic [4:0]               wb_dst,
  output logic [`RV_XLEN-1:0]      wb_r,
  output logic                     wb_we
);

  riscv_wb_pkg::opcode_e   opcode;
  riscv_wb_pkg::mem_size_e func3;
  logic [4:0]              dst;

  logic [`RV_EXC_SIZE-1:0] exception;
  logic                    mem_exc;
  logic                    writes_rd;

  logic [7:0]              m_qb;
  logic [15:0]             m_qh;
  logic [`RV_XLEN-1:0]     m_data;

  assign opcode = riscv_wb_pkg::opcode_e'(stage.instr[6:2]);
  assign func3  = riscv_wb_pkg::mem_size_e'(stage.instr[14:12]);
  assign dst    = stage.instr[11:7];

  // Hold everything until the memory answers
  assign wb_stall = dmem.req & ~dmem.ack;

  ////////////////////////////////////////////////////////////
  // Load data
  ////////////////////////////////////////////////////////////

  // Requested lanes down to bit 0
  assign m_qb = 8'(dmem.q >> {dmem.adr[1:0], 3'b000});
  assign m_qh = 16'(dmem.q >> {dmem.adr[1:0], 3'b000});

  always_comb
    case (func3)
      riscv_wb_pkg::SZ_B:  m_data = {{(`RV_XLEN-8){m_qb[7]}}, m_qb};
      riscv_wb_pkg::SZ_H:  m_data = {{(`RV_XLEN-16){m_qh[15]}}, m_qh};
      riscv_wb_pkg::SZ_BU: m_data = {{(`RV_XLEN-8){1'b0}}, m_qb};
      riscv_wb_pkg::SZ_HU: m_data = {{(`RV_XLEN-16){1'b0}}, m_qh};
      default:             m_data = dmem.q;
    endcase

  ////////////////////////////////////////////////////////////
  // Exceptions
  ////////////////////////////////////////////////////////////

  // Memory flags land in the load or store causes
  always_comb
  begin
    exception = '0;
    if (dmem.ack && opcode == riscv_wb_pkg::OPC_LOAD)
    begin
      exception[riscv_wb_pkg::CAUSE_MISALIGNED_LOAD]   = dmem.misaligned;
      exception[riscv_wb_pkg::CAUSE_LOAD_ACCESS_FAULT] = dmem.fault;
    end
    if (dmem.ack && opcode == riscv_wb_pkg::OPC_STORE)
    begin
      exception[riscv_wb_pkg::CAUSE_MISALIGNED_STORE]   = dmem.misaligned;
      exception[riscv_wb_pkg::CAUSE_STORE_ACCESS_FAULT] = dmem.fault;
    end
  end

  // Only memory causes exist in this slice
  assign mem_exc = |exception;

  // No destination write for these
  always_comb
    case (opcode)
      riscv_wb_pkg::OPC_STORE,
      riscv_wb_pkg::OPC_STORE_FP,
      riscv_wb_pkg::OPC_BRANCH,
      riscv_wb_pkg::OPC_MISC_MEM: writes_rd = 1'b0;
      default:                    writes_rd = 1'b1;
    endcase

  ////////////////////////////////////////////////////////////
  // Write-back registers
  ////////////////////////////////////////////////////////////

  // Valid and we pulse once per instruction
  always_ff @(posedge clk or negedge rstn)
    if (!rstn)
    begin
      wb_pc        <= `RV_PC_INIT;
      wb_instr     <= riscv_wb_pkg::INSTR_NOP;
      wb_exception <= '0;
      wb_valid     <= 1'b0;
      wb_we        <= 1'b0;
    end
    else
    begin
      wb_valid <= ~stage.bubble & ~wb_stall;
      wb_we    <= ~stage.bubble & ~wb_stall & ~mem_exc & (|dst) & writes_rd;
      if (!wb_stall)
      begin
        wb_pc        <= stage.pc;
        wb_instr     <= stage.instr;
        wb_exception <= exception;
      end
    end

  // Result, destination and bad address
  always_ff @(posedge clk)
    if (!wb_stall)
    begin
      wb_dst     <= dst;
      wb_r       <= (opcode == riscv_wb_pkg::OPC_LOAD) ? m_data : stage.r;
      wb_badaddr <= mem_exc ? dmem.adr : stage.pc;
    end

endmodule

/* verilog/riscv_wb_cfg.svh */
// Build constants for the RISC-V memory access and write-back slice
`ifndef RISCV_WB_CFG_SVH
`define RISCV_WB_CFG_SVH

// Data path and instruction widths
`define RV_XLEN           32
`define RV_ILEN           32

// Pc shown by write-back out of reset
`define RV_PC_INIT        'h200

// Exception vector width with one bit per cause
`define RV_EXC_SIZE       16

// Data memory depth in words
`define RV_DMEM_WORDS     256

// Longest extra wait before the memory acknowledges
`define RV_DMEM_MAX_WAIT  3

`endif

/* verilog/riscv_wb_pkg.sv */
// Opcode, load size and exception cause types plus the memory stage record
`include "riscv_wb_cfg.svh"

package riscv_wb_pkg;

  // Major opcodes, instruction bits 6:2
  typedef enum logic [4:0] {
    OPC_LOAD     = 5'b00000,
    OPC_MISC_MEM = 5'b00011,
    OPC_OP_IMM   = 5'b00100,
    OPC_AUIPC    = 5'b00101,
    OPC_STORE    = 5'b01000,
    OPC_STORE_FP = 5'b01001,
    OPC_OP       = 5'b01100,
    OPC_LUI      = 5'b01101,
    OPC_BRANCH   = 5'b11000,
    OPC_JALR     = 5'b11001,
    OPC_JAL      = 5'b11011,
    OPC_SYSTEM   = 5'b11100
  } opcode_e;

  // Access size from func3
  typedef enum logic [2:0] {
    SZ_B  = 3'b000,
    SZ_H  = 3'b001,
    SZ_W  = 3'b010,
    SZ_BU = 3'b100,
    SZ_HU = 3'b101
  } mem_size_e;

  // Bit positions in the exception vector
  typedef enum logic [3:0] {
    CAUSE_MISALIGNED_LOAD    = 4'd4,
    CAUSE_LOAD_ACCESS_FAULT  = 4'd5,
    CAUSE_MISALIGNED_STORE   = 4'd6,
    CAUSE_STORE_ACCESS_FAULT = 4'd7
  } cause_e;

  // addi x0,x0,0
  localparam logic [`RV_ILEN-1:0] INSTR_NOP = 'h13;

  // Contents of the memory stage register
  typedef struct packed {
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_ILEN-1:0] instr;
    logic [`RV_XLEN-1:0] r;
    logic [`RV_XLEN-1:0] adr;
    logic                bubble;
  } mem_stage_t;

endpackage
